/* hw/squelch_consts.svh */
// squelch constants
`ifndef SQUELCH_CONSTS_SVH
`define SQUELCH_CONSTS_SVH

////////////////////////////////////////////////////////////
// datapath widths and depths
////////////////////////////////////////////////////////////

`define SQ_SAMP_W   12
`define SQ_MAG_W    16
`define SQ_NUM_CH   4
`define SQ_DELAY    24
`define SQ_AVG_LOG2 4
`define SQ_PAD_W    8

////////////////////////////////////////////////////////////
// register map and reset values
////////////////////////////////////////////////////////////

`define SQ_ADDR_THRESH 8'h00
`define SQ_ADDR_PAD    8'h04
`define SQ_ADDR_ENABLE 8'h08
`define SQ_ADDR_STATUS 8'h0C

`define SQ_RST_THRESH  16'h0010
`define SQ_RST_PAD     8'd7
`define SQ_RST_ENABLE  4'hF

`endif

/* hw/iq_pkg.sv */
// sample stream types
`include "squelch_consts.svh"

package iq_pkg;

  ////////////////////////////////////////////////////////////
  // complex baseband sample
  ////////////////////////////////////////////////////////////

  // two's complement, as delivered by the converter
  typedef struct packed {
    logic signed [`SQ_SAMP_W-1:0] i;
    logic signed [`SQ_SAMP_W-1:0] q;
  } iq_t;

  // sample plus its qualifier, no back-pressure
  typedef struct packed {
    logic valid;
    iq_t  iq;
  } iq_beat_t;

  ////////////////////////////////////////////////////////////
  // magnitude domain
  ////////////////////////////////////////////////////////////

  // unsigned, wide enough for 1.5x a full-scale component
  typedef logic [`SQ_MAG_W-1:0] mag_t;

endpackage

/* hw/apb_pkg.sv */
// bus and configuration types
`include "squelch_consts.svh"

package apb_pkg;

  // requester side of the bus
  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  // completer side
  typedef struct packed {
    logic        pready;
    logic [31:0] prdata;
    logic        pslverr;
  } apb_rsp_t;

  // configuration fanned out to every channel
  typedef struct packed {
    iq_pkg::mag_t            threshold;
    logic [`SQ_PAD_W-1:0]    pad_len;
    logic [`SQ_NUM_CH-1:0]   enable;
  } sq_cfg_t;

endpackage

/* hw/iq_delay_line.sv */
// generic payload delay line
module iq_delay_line #(
  parameter type         T     = logic,
  parameter int unsigned DEPTH = 4
) (
  input  logic clk,
  input  logic rst_n,
  input  T     din,
  output T     dout
);

  ////////////////////////////////////////////////////////////
  // shift register
  ////////////////////////////////////////////////////////////

  T stages [DEPTH];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = 0; s < DEPTH; s++) begin
        stages[s] <= '0;
      end
    end else begin
      stages[0] <= din;
      for (int s = 1; s < DEPTH; s++) begin
        stages[s] <= stages[s-1];
      end
    end
  end

  // oldest entry
  assign dout = stages[DEPTH-1];

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  // magnitude, average and gate take four cycles in total,
  // the samples must not overtake their own decision
  a_depth_covers_pipeline : assert property (
    @(posedge clk) disable iff (!rst_n)
    DEPTH >= 4
  ) else $error("iq_delay_line: DEPTH %0d shorter than decision pipeline", DEPTH);

endmodule

/* hw/iq_magnitude.sv */
// complex magnitude estimate
`include "squelch_consts.svh"

module iq_magnitude (
  input  logic             clk,
  input  logic             rst_n,
  input  iq_pkg::iq_beat_t sample,
  output iq_pkg::mag_t     mag,
  output logic             mag_valid
);

  import iq_pkg::*;

  localparam int unsigned EXT_W = `SQ_MAG_W - `SQ_SAMP_W;

  logic signed [`SQ_MAG_W-1:0] i_ext;
  logic signed [`SQ_MAG_W-1:0] q_ext;
  mag_t                        abs_i;
  mag_t                        abs_q;
  logic                        abs_valid;

  // sign extension before negation so -2048 stays representable
  assign i_ext = {{EXT_W{sample.iq.i[`SQ_SAMP_W-1]}}, sample.iq.i};
  assign q_ext = {{EXT_W{sample.iq.q[`SQ_SAMP_W-1]}}, sample.iq.q};

  ////////////////////////////////////////////////////////////
  // stage one, absolute values
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    abs_i <= i_ext[`SQ_MAG_W-1] ? mag_t'(-i_ext) : mag_t'(i_ext);
    abs_q <= q_ext[`SQ_MAG_W-1] ? mag_t'(-q_ext) : mag_t'(q_ext);
  end

  ////////////////////////////////////////////////////////////
  // stage two, max plus half of min
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (abs_i >= abs_q) begin
      mag <= abs_i + (abs_q >> 1);
    end else begin
      mag <= abs_q + (abs_i >> 1);
    end
  end

  // qualifier follows the data through both stages
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      abs_valid <= 1'b0;
      mag_valid <= 1'b0;
    end else begin
      abs_valid <= sample.valid;
      mag_valid <= abs_valid;
    end
  end

  // absolute value of a raw input component
  function automatic int comp_abs(logic signed [`SQ_SAMP_W-1:0] x);
    return (x < 0) ? -int'(x) : int'(x);
  endfunction

  // estimate bounded by |i| + |q| of the input sample two cycles back
  a_mag_bounded : assert property (
    @(posedge clk) disable iff (!rst_n)
    mag_valid |-> (int'(mag) <= comp_abs($past(sample.iq.i, 2))
                                + comp_abs($past(sample.iq.q, 2)))
  ) else $error("iq_magnitude: estimate %h above |i|+|q|", mag);

endmodule

/* hw/boxcar_avg.sv */
// boxcar magnitude averager
`include "squelch_consts.svh"

module boxcar_avg (
  input  logic         clk,
  input  logic         rst_n,
  input  iq_pkg::mag_t mag,
  input  logic         mag_valid,
  output iq_pkg::mag_t avg
);

  import iq_pkg::*;

  localparam int unsigned LEN   = 1 << `SQ_AVG_LOG2;
  localparam int unsigned SUM_W = `SQ_MAG_W + `SQ_AVG_LOG2;

  mag_t             hist [LEN];
  logic [SUM_W-1:0] sum_q;
  logic [SUM_W-1:0] sum_next;

  // add newest, drop oldest; holds on invalid cycles
  always_comb begin
    sum_next = sum_q;
    if (mag_valid) begin
      sum_next = sum_q + SUM_W'(mag) - SUM_W'(hist[LEN-1]);
    end
  end

  ////////////////////////////////////////////////////////////
  // history, sum and average
  ////////////////////////////////////////////////////////////

  // history is cleared with the sum so the two stay consistent
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int k = 0; k < LEN; k++) begin
        hist[k] <= '0;
      end
      sum_q <= '0;
      avg   <= '0;
    end else if (mag_valid) begin
      hist[0] <= mag;
      for (int k = 1; k < LEN; k++) begin
        hist[k] <= hist[k-1];
      end
      sum_q <= sum_next;
      // average lands one cycle after the magnitude
      avg   <= sum_next[SUM_W-1:`SQ_AVG_LOG2];
    end
  end

endmodule

/* hw/squelch_gate.sv */
// squelch gate decision
`include "squelch_consts.svh"

module squelch_gate (
  input  logic                 clk,
  input  logic                 rst_n,
  input  iq_pkg::mag_t         avg,
  input  logic                 mag_valid,
  input  iq_pkg::mag_t         threshold,
  input  logic [`SQ_PAD_W-1:0] pad_len,
  output logic                 gate_open
);

  logic                 above;
  logic [`SQ_PAD_W-1:0] pad_cnt;

  // strictly greater, a threshold of zero passes any nonzero signal
  assign above = (avg > threshold);

  ////////////////////////////////////////////////////////////
  // pad counter
  ////////////////////////////////////////////////////////////

  // starts saturated so the gate comes out of reset closed
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pad_cnt <= `SQ_RST_PAD;
    end else if (above) begin
      pad_cnt <= '0;
    end else if (pad_cnt > pad_len) begin
      // pad length was lowered under us
      pad_cnt <= pad_len;
    end else if (mag_valid && (pad_cnt < pad_len)) begin
      pad_cnt <= pad_cnt + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // gate
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gate_open <= 1'b0;
    end else begin
      gate_open <= above || (pad_cnt < pad_len);
    end
  end

  // the counter may only sit above pad_len right after pad_len drops
  a_pad_in_range : assert property (
    @(posedge clk) disable iff (!rst_n)
    (pad_cnt > pad_len) |-> (pad_len < $past(pad_len))
  ) else $error("squelch_gate: pad_cnt %h above pad_len %h", pad_cnt, pad_len);

endmodule

/* hw/squelch_chan.sv */
// single squelch channel
`include "squelch_consts.svh"

module squelch_chan (
  input  logic             clk,
  input  logic             rst_n,
  input  iq_pkg::iq_beat_t sample_in,
  input  apb_pkg::sq_cfg_t cfg,
  input  logic             ch_enable,
  output iq_pkg::iq_beat_t sample_out,
  output logic             gate_open
);

  import iq_pkg::*;

  mag_t     mag;
  mag_t     avg;
  logic     mag_valid;
  logic     avg_valid;
  iq_beat_t dly_beat;
  logic     out_valid;
  iq_t      out_iq;

  ////////////////////////////////////////////////////////////
  // decision path
  ////////////////////////////////////////////////////////////

  iq_magnitude mag_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .sample    (sample_in),
    .mag       (mag),
    .mag_valid (mag_valid)
  );

  boxcar_avg avg_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .mag       (mag),
    .mag_valid (mag_valid),
    .avg       (avg)
  );

  // qualifier lined up with the registered average
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      avg_valid <= 1'b0;
    end else begin
      avg_valid <= mag_valid;
    end
  end

  squelch_gate gate_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .avg       (avg),
    .mag_valid (avg_valid),
    .threshold (cfg.threshold),
    .pad_len   (cfg.pad_len),
    .gate_open (gate_open)
  );

  ////////////////////////////////////////////////////////////
  // sample path
  ////////////////////////////////////////////////////////////

  // one stage short, the output register makes up the rest
  iq_delay_line #(
    .T     (iq_beat_t),
    .DEPTH (`SQ_DELAY - 1)
  ) dly_i (
    .clk   (clk),
    .rst_n (rst_n),
    .din   (sample_in),
    .dout  (dly_beat)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= dly_beat.valid & gate_open & ch_enable;
    end
  end

  // data is never touched, only the valid is suppressed
  always_ff @(posedge clk) begin
    out_iq <= dly_beat.iq;
  end

  assign sample_out = '{valid: out_valid, iq: out_iq};

endmodule

/* hw/squelch_regs.sv */
// squelch register file
`include "squelch_consts.svh"

module squelch_regs (
  input  logic                  clk,
  input  logic                  rst_n,
  input  apb_pkg::apb_req_t     apb_req,
  output apb_pkg::apb_rsp_t     apb_rsp,
  output apb_pkg::sq_cfg_t      cfg,
  input  logic [`SQ_NUM_CH-1:0] gate_status
);

  import apb_pkg::*;

  sq_cfg_t     cfg_q;
  logic        access;
  logic        addr_hit;
  logic        ro_write;
  logic [31:0] rd_data;

  ////////////////////////////////////////////////////////////
  // decode
  ////////////////////////////////////////////////////////////

  // zero wait states, everything happens in the access phase
  assign access = apb_req.psel & apb_req.penable;

  always_comb begin
    rd_data  = '0;
    addr_hit = 1'b1;
    case (apb_req.paddr)
      `SQ_ADDR_THRESH: rd_data = 32'(cfg_q.threshold);
      `SQ_ADDR_PAD:    rd_data = 32'(cfg_q.pad_len);
      `SQ_ADDR_ENABLE: rd_data = 32'(cfg_q.enable);
      `SQ_ADDR_STATUS: rd_data = 32'(gate_status);
      default:         addr_hit = 1'b0;
    endcase
  end

  // status is read only
  assign ro_write = apb_req.pwrite && (apb_req.paddr == `SQ_ADDR_STATUS);

  ////////////////////////////////////////////////////////////
  // writable registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg_q.threshold <= `SQ_RST_THRESH;
      cfg_q.pad_len   <= `SQ_RST_PAD;
      cfg_q.enable    <= `SQ_RST_ENABLE;
    end else if (access && apb_req.pwrite) begin
      case (apb_req.paddr)
        `SQ_ADDR_THRESH: cfg_q.threshold <= apb_req.pwdata[`SQ_MAG_W-1:0];
        `SQ_ADDR_PAD:    cfg_q.pad_len   <= apb_req.pwdata[`SQ_PAD_W-1:0];
        `SQ_ADDR_ENABLE: cfg_q.enable    <= apb_req.pwdata[`SQ_NUM_CH-1:0];
        default: ;
      endcase
    end
  end

  assign cfg = cfg_q;

  ////////////////////////////////////////////////////////////
  // response
  ////////////////////////////////////////////////////////////

  assign apb_rsp.pready  = 1'b1;
  assign apb_rsp.prdata  = (access && !apb_req.pwrite) ? rd_data : '0;
  assign apb_rsp.pslverr = access & (~addr_hit | ro_write);

  // requester must hold psel through the access phase
  a_penable_needs_psel : assert property (
    @(posedge clk) disable iff (!rst_n)
    apb_req.penable |-> apb_req.psel
  ) else $error("squelch_regs: penable high without psel, paddr %h", apb_req.paddr);

endmodule

/* hw/squelch_top.sv */
// four channel squelch
`include "squelch_consts.svh"

module squelch_top (
  input  logic              clk,
  input  logic              rst_n,
  input  apb_pkg::apb_req_t apb_req,
  output apb_pkg::apb_rsp_t apb_rsp,
  input  iq_pkg::iq_beat_t  samples_in  [`SQ_NUM_CH],
  output iq_pkg::iq_beat_t  samples_out [`SQ_NUM_CH]
);

  import apb_pkg::*;

  sq_cfg_t               cfg;
  logic [`SQ_NUM_CH-1:0] gate_status;

  ////////////////////////////////////////////////////////////
  // configuration
  ////////////////////////////////////////////////////////////

  squelch_regs regs_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .apb_req     (apb_req),
    .apb_rsp     (apb_rsp),
    .cfg         (cfg),
    .gate_status (gate_status)
  );

  ////////////////////////////////////////////////////////////
  // channels
  ////////////////////////////////////////////////////////////

  // shared threshold and pad, per-channel enable
  for (genvar ch = 0; ch < `SQ_NUM_CH; ch++) begin : g_chan
    squelch_chan chan_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .sample_in  (samples_in[ch]),
      .cfg        (cfg),
      .ch_enable  (cfg.enable[ch]),
      .sample_out (samples_out[ch]),
      .gate_open  (gate_status[ch])
    );
  end

endmodule

/* dv/squelch_tb.sv */
// squelch testbench
`include "squelch_consts.svh"

module squelch_tb;

  import iq_pkg::*;
  import apb_pkg::*;

  localparam int CLK_PERIOD = 8;
  localparam int IN_DLY     = 1;
  localparam int NCH        = `SQ_NUM_CH;
  localparam int DLY        = `SQ_DELAY;
  localparam int AVG_LEN    = 1 << `SQ_AVG_LOG2;
  localparam int SAMP_W     = `SQ_SAMP_W;

  // stream lengths per test, in samples
  localparam int N_REG   = 150;
  localparam int N_XPAR  = 200;
  localparam int N_BLOCK = 150;
  localparam int N_BURST = 40;
  localparam int N_TAIL  = 80;
  localparam int N_INDEP = 100;
  localparam int N_GAPS  = 300;
  localparam int N_FLUSH = DLY + 8;
  localparam int TOTAL_SAMPLES = N_REG + N_XPAR + N_BLOCK + N_BURST + N_TAIL
                               + N_INDEP + N_GAPS + 6 * N_FLUSH;

  logic     clk;
  logic     rst_n;
  apb_req_t apb_req;
  apb_rsp_t apb_rsp;
  iq_beat_t samples_in  [NCH];
  iq_beat_t samples_out [NCH];

  int          err_cnt;
  int          test_cnt;
  int          test_fail_cnt;
  int          test_err_base;
  int          vcnt [NCH];
  logic [31:0] rd_data;
  logic [NCH-1:0] status_snap;

  // reference model state
  mag_t                 thr_m;
  logic [`SQ_PAD_W-1:0] pad_len_m;
  logic [NCH-1:0]       en_m;
  logic [NCH-1:0]       gate_m;
  logic [`SQ_PAD_W-1:0] pad_m [NCH];
  mag_t                 m1 [NCH];
  mag_t                 m2 [NCH];
  logic                 v1 [NCH];
  logic                 v2 [NCH];
  mag_t                 win [NCH][AVG_LEN];
  mag_t                 avg_m [NCH];
  logic                 avg_v [NCH];
  iq_beat_t             in_hist [NCH][DLY-1];
  iq_beat_t             exp_out [NCH];

  squelch_top dut_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .apb_req     (apb_req),
    .apb_rsp     (apb_rsp),
    .samples_in  (samples_in),
    .samples_out (samples_out)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(TOTAL_SAMPLES * CLK_PERIOD * 2);
    $display("watchdog expired, the tests did not finish in time");
    $display("Simulation FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  // max plus half of min
  function automatic mag_t est_mag(iq_t s);
    int ai;
    int aq;
    ai = s.i;
    aq = s.q;
    if (ai < 0) ai = -ai;
    if (aq < 0) aq = -aq;
    if (ai >= aq) return mag_t'(ai + aq / 2);
    return mag_t'(aq + ai / 2);
  endfunction

  always @(posedge clk or negedge rst_n) begin : model
    int sum;
    if (!rst_n) begin
      thr_m     = `SQ_RST_THRESH;
      pad_len_m = `SQ_RST_PAD;
      en_m      = `SQ_RST_ENABLE;
      gate_m    = '0;
      for (int ch = 0; ch < NCH; ch++) begin
        pad_m[ch]   = `SQ_RST_PAD;
        m1[ch]      = '0;
        m2[ch]      = '0;
        v1[ch]      = 1'b0;
        v2[ch]      = 1'b0;
        avg_m[ch]   = '0;
        avg_v[ch]   = 1'b0;
        exp_out[ch] = '0;
        for (int k = 0; k < AVG_LEN; k++) win[ch][k] = '0;
        for (int k = 0; k < DLY - 1; k++) in_hist[ch][k] = '0;
      end
    end else begin
      for (int ch = 0; ch < NCH; ch++) begin
        // beat released now, gated by the decision of this cycle
        exp_out[ch].iq    = in_hist[ch][DLY-2].iq;
        exp_out[ch].valid = in_hist[ch][DLY-2].valid & gate_m[ch] & en_m[ch];
        for (int k = DLY - 2; k > 0; k--) in_hist[ch][k] = in_hist[ch][k-1];
        in_hist[ch][0] = samples_in[ch];
        // gate from the current average and pad count
        gate_m[ch] = (avg_m[ch] > thr_m) || (pad_m[ch] < pad_len_m);
        if (avg_m[ch] > thr_m) begin
          pad_m[ch] = '0;
        end else if (pad_m[ch] > pad_len_m) begin
          pad_m[ch] = pad_len_m;
        end else if (avg_v[ch] && (pad_m[ch] < pad_len_m)) begin
          pad_m[ch] = pad_m[ch] + 1'b1;
        end
        // mean of the last AVG_LEN valid magnitudes
        avg_v[ch] = v2[ch];
        if (v2[ch]) begin
          for (int k = AVG_LEN - 1; k > 0; k--) win[ch][k] = win[ch][k-1];
          win[ch][0] = m2[ch];
          sum = 0;
          for (int k = 0; k < AVG_LEN; k++) sum += win[ch][k];
          avg_m[ch] = mag_t'(sum / AVG_LEN);
        end
        m2[ch] = m1[ch];
        v2[ch] = v1[ch];
        m1[ch] = est_mag(samples_in[ch].iq);
        v1[ch] = samples_in[ch].valid;
      end
      // writes land after this cycle's decisions
      if (apb_req.psel && apb_req.penable && apb_req.pwrite) begin
        case (apb_req.paddr)
          `SQ_ADDR_THRESH: thr_m     = apb_req.pwdata[`SQ_MAG_W-1:0];
          `SQ_ADDR_PAD:    pad_len_m = apb_req.pwdata[`SQ_PAD_W-1:0];
          `SQ_ADDR_ENABLE: en_m      = apb_req.pwdata[NCH-1:0];
          default: ;
        endcase
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // output checks
  ////////////////////////////////////////////////////////////

  for (genvar ch = 0; ch < NCH; ch++) begin : g_chk
    a_out_valid : assert property (
      @(posedge clk) disable iff (!rst_n)
      samples_out[ch].valid === exp_out[ch].valid
    ) else begin
      err_cnt = err_cnt + 1;
      $display("FAILED samples_out[%0d].valid: got 0x%h, expected 0x%h", ch,
               $sampled(samples_out[ch].valid), $sampled(exp_out[ch].valid));
    end

    a_out_data : assert property (
      @(posedge clk) disable iff (!rst_n)
      samples_out[ch].iq === exp_out[ch].iq
    ) else begin
      err_cnt = err_cnt + 1;
      $display("FAILED samples_out[%0d].iq: got 0x%h, expected 0x%h", ch,
               $sampled(samples_out[ch].iq), $sampled(exp_out[ch].iq));
    end
  end

  // released beats per channel
  always @(negedge clk) begin
    for (int ch = 0; ch < NCH; ch++) begin
      if (rst_n && samples_out[ch].valid) vcnt[ch]++;
    end
  end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  task automatic step();
    @(posedge clk);
    #IN_DLY;
  endtask

  task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    a_value : assert (got === exp) else begin
      err_cnt = err_cnt + 1;
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                           input logic exp_err);
    apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
    step();
    apb_req.penable = 1'b1;
    @(negedge clk);
    expect_eq($sformatf("pready write 0x%h", addr), 32'(apb_rsp.pready), 32'h1);
    expect_eq($sformatf("pslverr write 0x%h", addr), 32'(apb_rsp.pslverr), 32'(exp_err));
    step();
    apb_req = '0;
  endtask

  // also snapshots the model gates during the access phase
  task automatic apb_read(input logic [7:0] addr, input logic exp_err);
    apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: '0};
    step();
    apb_req.penable = 1'b1;
    @(negedge clk);
    rd_data     = apb_rsp.prdata;
    status_snap = gate_m;
    expect_eq($sformatf("pready read 0x%h", addr), 32'(apb_rsp.pready), 32'h1);
    expect_eq($sformatf("pslverr read 0x%h", addr), 32'(apb_rsp.pslverr), 32'(exp_err));
    step();
    apb_req = '0;
  endtask

  task automatic set_cfg(input logic [31:0] thr, input logic [31:0] pad,
                         input logic [31:0] en);
    apb_write(`SQ_ADDR_THRESH, thr, 1'b0);
    apb_write(`SQ_ADDR_PAD, pad, 1'b0);
    apb_write(`SQ_ADDR_ENABLE, en, 1'b0);
    for (int ch = 0; ch < NCH; ch++) vcnt[ch] = 0;
  endtask

  task automatic put_beat(input int ch, input logic valid, input int i, input int q);
    samples_in[ch] = '{valid: valid, iq: '{i: SAMP_W'(i), q: SAMP_W'(q)}};
  endtask

  task automatic drive_idle(input int n);
    for (int ch = 0; ch < NCH; ch++) put_beat(ch, 1'b0, 0, 0);
    repeat (n) step();
  endtask

  function automatic int rand_nonzero();
    int v;
    v = int'($urandom_range(1, 2047));
    return ($urandom_range(0, 1) != 0) ? -v : v;
  endfunction

  function automatic int rand_sign(input int amp);
    return ($urandom_range(0, 1) != 0) ? -amp : amp;
  endfunction

  task automatic begin_test();
    test_err_base = err_cnt;
  endtask

  task automatic end_test(input string name);
    test_cnt++;
    if (err_cnt == test_err_base) begin
      $display("test %s: ok", name);
    end else begin
      test_fail_cnt++;
      $display("test %s: %0d errors", name, err_cnt - test_err_base);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int amp_i [NCH];
    int amp_q [NCH];
    void'($urandom(24));
    rst_n         = 1'b0;
    apb_req       = '0;
    err_cnt       = 0;
    test_cnt      = 0;
    test_fail_cnt = 0;
    for (int ch = 0; ch < NCH; ch++) begin
      samples_in[ch] = '0;
      vcnt[ch]       = 0;
    end
    amp_i = '{40, 300, 600, 120};
    amp_q = '{20, 0, 0, 60};
    repeat (3) @(posedge clk);
    #IN_DLY;
    rst_n = 1'b1;

    // register access
    begin_test();
    apb_read(`SQ_ADDR_THRESH, 1'b0);
    expect_eq("prdata THRESH", rd_data, 32'h0010);
    apb_read(`SQ_ADDR_PAD, 1'b0);
    expect_eq("prdata PAD", rd_data, 32'h0007);
    apb_read(`SQ_ADDR_ENABLE, 1'b0);
    expect_eq("prdata ENABLE", rd_data, 32'h000F);
    apb_read(`SQ_ADDR_STATUS, 1'b0);
    expect_eq("prdata STATUS", rd_data, 32'h0);
    set_cfg(32'hFFFF_4321, 32'h0000_12AB, 32'hFFFF_FFF5);
    apb_read(`SQ_ADDR_THRESH, 1'b0);
    expect_eq("prdata THRESH", rd_data, 32'h4321);
    apb_read(`SQ_ADDR_PAD, 1'b0);
    expect_eq("prdata PAD", rd_data, 32'h00AB);
    apb_read(`SQ_ADDR_ENABLE, 1'b0);
    expect_eq("prdata ENABLE", rd_data, 32'h0005);
    apb_write(`SQ_ADDR_STATUS, 32'hF, 1'b1);
    apb_read(`SQ_ADDR_STATUS, 1'b0);
    expect_eq("prdata STATUS", rd_data, 32'(status_snap));
    apb_read(8'h10, 1'b1);
    expect_eq("prdata unmapped", rd_data, 32'h0);
    apb_write(8'h20, 32'h1, 1'b1);
    end_test("register access");

    // transparency
    begin_test();
    set_cfg(32'h0, 32'd7, 32'hF);
    repeat (N_XPAR) begin
      for (int ch = 0; ch < NCH; ch++) put_beat(ch, 1'b1, rand_nonzero(), rand_nonzero());
      step();
    end
    drive_idle(N_FLUSH);
    for (int ch = 0; ch < NCH; ch++) begin
      assert (vcnt[ch] > 0) else begin
        err_cnt = err_cnt + 1;
        $display("channel %0d never opened with the threshold at zero", ch);
      end
    end
    end_test("transparency");

    // blocking
    begin_test();
    set_cfg(32'hFFFF, 32'd0, 32'hF);
    repeat (N_BLOCK) begin
      for (int ch = 0; ch < NCH; ch++) put_beat(ch, 1'b1, rand_nonzero(), rand_nonzero());
      step();
    end
    drive_idle(N_FLUSH);
    for (int ch = 0; ch < NCH; ch++) expect_eq($sformatf("vcnt[%0d]", ch), vcnt[ch], 0);
    end_test("blocking");

    // pad hold after a burst
    begin_test();
    set_cfg(32'h0100, 32'd10, 32'hF);
    repeat (N_BURST) begin
      for (int ch = 0; ch < NCH; ch++) put_beat(ch, 1'b1, 1000, -500);
      step();
    end
    repeat (N_TAIL) begin
      for (int ch = 0; ch < NCH; ch++) put_beat(ch, 1'b1, 0, 0);
      step();
    end
    drive_idle(N_FLUSH);
    for (int ch = 0; ch < NCH; ch++) begin
      assert (vcnt[ch] > N_BURST) else begin
        err_cnt = err_cnt + 1;
        $display("channel %0d did not hold the gate past the burst", ch);
      end
    end
    end_test("pad hold");

    // independent channels, channel 2 disabled
    begin_test();
    set_cfg(32'h0080, 32'd4, 32'hB);
    repeat (N_INDEP) begin
      for (int ch = 0; ch < NCH; ch++) begin
        put_beat(ch, 1'b1, rand_sign(amp_i[ch]), rand_sign(amp_q[ch]));
      end
      step();
    end
    drive_idle(1);
    apb_read(`SQ_ADDR_STATUS, 1'b0);
    expect_eq("prdata STATUS", rd_data, 32'(status_snap));
    drive_idle(N_FLUSH);
    expect_eq("vcnt[2]", vcnt[2], 0);
    end_test("independence");

    // random gaps in valid
    begin_test();
    set_cfg(32'h0060, 32'd5, 32'hF);
    repeat (N_GAPS) begin
      for (int ch = 0; ch < NCH; ch++) begin
        put_beat(ch, logic'($urandom_range(0, 1)), int'($urandom_range(0, 400)) - 200,
                 int'($urandom_range(0, 400)) - 200);
      end
      step();
    end
    drive_idle(1);
    apb_read(`SQ_ADDR_STATUS, 1'b0);
    expect_eq("prdata STATUS", rd_data, 32'(status_snap));
    drive_idle(N_FLUSH);
    end_test("valid gaps");

    $display("tests %0d, failing tests %0d, errors %0d", test_cnt, test_fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* build.f */
+incdir+hw
hw/iq_pkg.sv
hw/apb_pkg.sv
hw/iq_delay_line.sv
hw/iq_magnitude.sv
hw/boxcar_avg.sv
hw/squelch_gate.sv
hw/squelch_chan.sv
hw/squelch_regs.sv
hw/squelch_top.sv
dv/squelch_tb.sv

/* Bender.yml */
package:
  name: squelch

sources:
  - include_dirs:
      - hw
    files:
      - hw/iq_pkg.sv
      - hw/apb_pkg.sv
      - hw/iq_delay_line.sv
      - hw/iq_magnitude.sv
      - hw/boxcar_avg.sv
      - hw/squelch_gate.sv
      - hw/squelch_chan.sv
      - hw/squelch_regs.sv
      - hw/squelch_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - dv/squelch_tb.sv
